/* design/mipsPkg.sv */
/*
  Shared types and encodings for the decode and execute slice.
  Holds the word and field widths, the ALU and immediate-mode enums
  and the opcode and function values of every supported instruction.
*/
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  funcT;
    typedef logic [4:0]  shamtT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt,
        aluSltu, aluSll, aluSrl, aluSra, aluLui, aluMul
    } aluOpT;

    typedef enum logic [1:0] {
        immSign, immZero, immUpper
    } immModeT;

    parameter opcodeT opRType    = 6'h00;
    parameter opcodeT opAddi     = 6'h08;
    parameter opcodeT opAddiu    = 6'h09;
    parameter opcodeT opSlti     = 6'h0a;
    parameter opcodeT opSltiu    = 6'h0b;
    parameter opcodeT opAndi     = 6'h0c;
    parameter opcodeT opOri      = 6'h0d;
    parameter opcodeT opXori     = 6'h0e;
    parameter opcodeT opLui      = 6'h0f;
    parameter opcodeT opSpecial2 = 6'h1c;  // mul lives here

    parameter funcT funcSll  = 6'h00;
    parameter funcT funcSrl  = 6'h02;
    parameter funcT funcSra  = 6'h03;
    parameter funcT funcSllv = 6'h04;
    parameter funcT funcSrlv = 6'h06;
    parameter funcT funcSrav = 6'h07;
    parameter funcT funcAdd  = 6'h20;
    parameter funcT funcAddu = 6'h21;
    parameter funcT funcSub  = 6'h22;
    parameter funcT funcSubu = 6'h23;
    parameter funcT funcAnd  = 6'h24;
    parameter funcT funcOr   = 6'h25;
    parameter funcT funcXor  = 6'h26;
    parameter funcT funcNor  = 6'h27;
    parameter funcT funcSlt  = 6'h2a;
    parameter funcT funcSltu = 6'h2b;
    parameter funcT funcMul  = 6'h02;  // Under opSpecial2

endpackage

/* design/controlDecoder.sv */
/*
  Main control decoder.
  Maps opcode and function code to the ALU operation, operand and
  destination selects, immediate mode and the write and illegal flags.
*/
`timescale 1ns/1ns

module controlDecoder (
    input  mipsPkg::opcodeT  opcode,
    input  mipsPkg::funcT    func,
    output mipsPkg::aluOpT   aluOp,
    output logic             aluSrc,
    output logic             regDst,
    output logic             regWrite,
    output logic             varShift,
    output logic             illegal,
    output mipsPkg::immModeT immMode
);
    import mipsPkg::*;

    always_comb begin
        aluOp    = aluAdd;
        aluSrc   = 1'b0;
        regDst   = 1'b0;
        regWrite = 1'b0;
        varShift = 1'b0;
        illegal  = 1'b0;
        immMode  = immSign;
        case (opcode)
            opRType: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (func)
                    funcAdd, funcAddu: aluOp = aluAdd;  // No overflow trap
                    funcSub, funcSubu: aluOp = aluSub;
                    funcAnd:           aluOp = aluAnd;
                    funcOr:            aluOp = aluOr;
                    funcXor:           aluOp = aluXor;
                    funcNor:           aluOp = aluNor;
                    funcSlt:           aluOp = aluSlt;
                    funcSltu:          aluOp = aluSltu;
                    funcSll:           aluOp = aluSll;
                    funcSrl:           aluOp = aluSrl;
                    funcSra:           aluOp = aluSra;
                    funcSllv: begin
                        aluOp    = aluSll;
                        varShift = 1'b1;
                    end
                    funcSrlv: begin
                        aluOp    = aluSrl;
                        varShift = 1'b1;
                    end
                    funcSrav: begin
                        aluOp    = aluSra;
                        varShift = 1'b1;
                    end
                    default: begin
                        regWrite = 1'b0;
                        illegal  = 1'b1;
                    end
                endcase
            end
            opSpecial2: begin
                regDst = 1'b1;
                if (func == funcMul) begin
                    aluOp    = aluMul;
                    regWrite = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            opAddi, opAddiu: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            opSlti, opSltiu: begin
                aluOp    = (opcode == opSlti) ? aluSlt : aluSltu;
                aluSrc   = 1'b1;
                regWrite = 1'b1;  // sltiu still sign extends
            end
            opAndi, opOri, opXori: begin
                aluOp    = (opcode == opAndi) ? aluAnd :
                           (opcode == opOri)  ? aluOr  : aluXor;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                immMode  = immZero;
            end
            opLui: begin
                aluOp    = aluLui;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                immMode  = immUpper;
            end
            default: illegal = 1'b1;
        endcase
    end

    // An illegal word must never reach the register file
    always_comb begin
        noWriteOnIllegal: assert final (!(illegal && regWrite));
    end

endmodule

/* design/registerFile.sv */
/*
  Register file, two read ports and one write port.
  Register 0 reads zero; a write in the current cycle is passed through
  to both read ports. Addresses at or above regCount read zero.
*/
`timescale 1ns/1ns

module registerFile #(
    parameter int regCount = 32
) (
    input  logic             Clock,
    input  logic             arstN,
    input  logic             writeEn,
    input  mipsPkg::regAddrT writeAddr,
    input  mipsPkg::regAddrT rsAddr,
    input  mipsPkg::regAddrT rtAddr,
    input  mipsPkg::wordT    writeData,
    output mipsPkg::wordT    rsData,
    output mipsPkg::wordT    rtData
);
    import mipsPkg::*;

    wordT regs [regCount];

    function automatic wordT readPort(input regAddrT addr);
        wordT value;
        if (addr == '0 || addr >= regCount)
            value = '0;
        else if (writeEn && addr == writeAddr)
            value = writeData;  // Write-through
        else
            value = regs[addr];
        return value;
    endfunction

    always_comb begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end else if (writeEn && writeAddr != '0 && writeAddr < regCount) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Destination numbers come from decode; none may exceed the file
    writeInRange: assert property (@(posedge Clock) disable iff (!arstN)
        writeEn |-> writeAddr < regCount);

endmodule

/* design/immediateGen.sv */
/*
  Immediate generator.
  Widens the 16-bit instruction immediate by sign extension, zero
  extension, or places it in the upper half for lui.
*/
`timescale 1ns/1ns

module immediateGen (
    input  logic [15:0]      imm16,
    input  mipsPkg::immModeT immMode,
    output mipsPkg::wordT    immData
);
    import mipsPkg::*;

    always_comb begin
        unique case (immMode)
            immSign:  immData = {{16{imm16[15]}}, imm16};
            immZero:  immData = {16'h0000, imm16};  // Logic immediates
            immUpper: immData = {imm16, 16'h0000};
            default:  immData = '0;
        endcase
    end

endmodule

/* design/decodeStage.sv */
/*
  Decode stage.
  Splits the instruction into fields, reads both source registers,
  builds the immediate and picks rt or rd as destination. Fully
  combinational apart from the register file write port.
*/
`timescale 1ns/1ns

module decodeStage #(
    parameter int regCount = 32
) (
    input  logic             Clock,
    input  logic             arstN,
    input  mipsPkg::wordT    instruction,
    input  logic             instrValid,
    input  logic             writeEn,
    input  mipsPkg::regAddrT writeAddr,
    input  mipsPkg::wordT    writeData,
    output mipsPkg::wordT    rsData,
    output mipsPkg::wordT    rtData,
    output mipsPkg::wordT    immData,
    output mipsPkg::regAddrT destAddr,
    output mipsPkg::shamtT   shamt,
    output mipsPkg::aluOpT   aluOp,
    output logic             aluSrc,
    output logic             varShift,
    output logic             regWrite,
    output logic             illegal
);
    import mipsPkg::*;

    regAddrT rsAddr;
    regAddrT rtAddr;
    regAddrT rdAddr;
    immModeT immMode;
    logic    regDst;
    logic    decRegWrite;
    logic    decIllegal;

    assign rsAddr = instruction[25:21];
    assign rtAddr = instruction[20:16];
    assign rdAddr = instruction[15:11];
    assign shamt  = instruction[10:6];

    assign destAddr = regDst ? rdAddr : rtAddr;
    assign regWrite = decRegWrite && instrValid;  // Idle cycles write nothing
    assign illegal  = decIllegal && instrValid;

    controlDecoder dec0 (
        .opcode  (instruction[31:26]),
        .func    (instruction[5:0]  ),
        .aluOp   (aluOp             ),
        .aluSrc  (aluSrc            ),
        .regDst  (regDst            ),
        .regWrite(decRegWrite       ),
        .varShift(varShift          ),
        .illegal (decIllegal        ),
        .immMode (immMode           )
    );

    registerFile #(.regCount(regCount)) reg0 (
        .Clock    (Clock    ),
        .arstN    (arstN    ),
        .writeEn  (writeEn  ),
        .writeAddr(writeAddr),
        .rsAddr   (rsAddr   ),
        .rtAddr   (rtAddr   ),
        .writeData(writeData),
        .rsData   (rsData   ),
        .rtData   (rtData   )
    );

    immediateGen imm0 (
        .imm16  (instruction[15:0]),
        .immMode(immMode          ),
        .immData(immData          )
    );

endmodule

/* design/aluUnit.sv */
/*
  Integer ALU.
  Add and subtract wrap, slt compares signed and sltu unsigned.
  Shifts act on operandA by shiftAmount; lui passes operandB through.
  mul returns the low 32 bits of the product.
*/
`timescale 1ns/1ns

module aluUnit (
    input  mipsPkg::wordT  operandA,
    input  mipsPkg::wordT  operandB,
    input  mipsPkg::shamtT shiftAmount,
    input  mipsPkg::aluOpT aluOp,
    output mipsPkg::wordT  result
);
    import mipsPkg::*;

    wordT sum;
    wordT difference;
    wordT product;
    logic lessSigned;
    logic lessUnsigned;

    assign sum          = operandA + operandB;
    assign difference   = operandA - operandB;
    assign product      = operandA * operandB;  // Truncated to 32 bits
    assign lessSigned   = $signed(operandA) < $signed(operandB);
    assign lessUnsigned = operandA < operandB;

    always_comb begin
        unique case (aluOp)
            aluAdd:  result = sum;
            aluSub:  result = difference;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluXor:  result = operandA ^ operandB;
            aluNor:  result = ~(operandA | operandB);
            aluSlt:  result = {31'd0, lessSigned};
            aluSltu: result = {31'd0, lessUnsigned};
            aluSll:  result = operandA << shiftAmount;
            aluSrl:  result = operandA >> shiftAmount;
            aluSra:  result = $signed(operandA) >>> shiftAmount;
            aluLui:  result = operandB;  // Already placed by immediateGen
            aluMul:  result = product;
            default: result = '0;
        endcase
    end

endmodule

/* design/executeStage.sv */
/*
  Execute stage.
  Captures the decode outputs in the ID/EX register, selects the ALU
  operands and registers the result for write-back one cycle later.
*/
`timescale 1ns/1ns

module executeStage (
    input  logic             Clock,
    input  logic             arstN,
    input  mipsPkg::wordT    rsData,
    input  mipsPkg::wordT    rtData,
    input  mipsPkg::wordT    immData,
    input  mipsPkg::regAddrT destAddr,
    input  mipsPkg::shamtT   shamt,
    input  mipsPkg::aluOpT   aluOp,
    input  logic             aluSrc,
    input  logic             varShift,
    input  logic             regWrite,
    input  logic             illegal,
    output logic             wbValid,
    output logic             illegalInstr,
    output mipsPkg::regAddrT wbAddr,
    output mipsPkg::wordT    wbData
);
    import mipsPkg::*;

    wordT    rsReg, rtReg, immReg;
    regAddrT destReg;
    shamtT   shamtReg;
    aluOpT   aluOpReg;
    logic    aluSrcReg, varShiftReg, regWriteReg, illegalReg;
    logic    isShift;
    wordT    operandA, operandB, aluResult;
    shamtT   shiftAmount;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            regWriteReg  <= 1'b0;
            illegalReg   <= 1'b0;
            wbValid      <= 1'b0;
            illegalInstr <= 1'b0;
        end else begin
            regWriteReg  <= regWrite;
            illegalReg   <= illegal;
            wbValid      <= regWriteReg;
            illegalInstr <= illegalReg;
        end
    end

    always_ff @(posedge Clock) begin  // ID/EX and result payload
        rsReg       <= rsData;
        rtReg       <= rtData;
        immReg      <= immData;
        destReg     <= destAddr;
        shamtReg    <= shamt;
        aluOpReg    <= aluOp;
        aluSrcReg   <= aluSrc;
        varShiftReg <= varShift;
        wbAddr      <= destReg;
        wbData      <= aluResult;
    end

    assign isShift     = aluOpReg inside {aluSll, aluSrl, aluSra};
    assign operandA    = isShift ? rtReg : rsReg;  // Shifts work on rt
    assign operandB    = aluSrcReg ? immReg : rtReg;
    assign shiftAmount = varShiftReg ? rsReg[4:0] : shamtReg;

    aluUnit alu0 (
        .operandA   (operandA   ),
        .operandB   (operandB   ),
        .shiftAmount(shiftAmount),
        .aluOp      (aluOpReg   ),
        .result     (aluResult  )
    );

    // Decoder exclusivity must survive both pipeline stages
    wbExclusive: assert property (@(posedge Clock) disable iff (!arstN)
        !(wbValid && illegalInstr));

endmodule

/* design/decodeExecTop.sv */
/*
  Top of the decode and execute slice.
  Connects the decode stage to the execute stage and loops the
  write-back result into the register file write port.
*/
`timescale 1ns/1ns

module decodeExecTop #(
    parameter int regCount = 32
) (
    input  logic             Clock,
    input  logic             arstN,
    input  mipsPkg::wordT    instruction,
    input  logic             instrValid,
    output logic             wbValid,
    output mipsPkg::regAddrT wbAddr,
    output mipsPkg::wordT    wbData,
    output logic             illegalInstr
);
    import mipsPkg::*;

    wordT    rsData, rtData, immData;
    regAddrT destAddr;
    shamtT   shamt;
    aluOpT   aluOp;
    logic    aluSrc, varShift, regWrite, illegal;

    decodeStage #(.regCount(regCount)) dec0 (
        .Clock      (Clock      ),
        .arstN      (arstN      ),
        .instruction(instruction),
        .instrValid (instrValid ),
        .writeEn    (wbValid    ),  // Write-back loop
        .writeAddr  (wbAddr     ),
        .writeData  (wbData     ),
        .rsData     (rsData     ),
        .rtData     (rtData     ),
        .immData    (immData    ),
        .destAddr   (destAddr   ),
        .shamt      (shamt      ),
        .aluOp      (aluOp      ),
        .aluSrc     (aluSrc     ),
        .varShift   (varShift   ),
        .regWrite   (regWrite   ),
        .illegal    (illegal    )
    );

    executeStage exe0 (
        .Clock       (Clock       ),
        .arstN       (arstN       ),
        .rsData      (rsData      ),
        .rtData      (rtData      ),
        .immData     (immData     ),
        .destAddr    (destAddr    ),
        .shamt       (shamt       ),
        .aluOp       (aluOp       ),
        .aluSrc      (aluSrc      ),
        .varShift    (varShift    ),
        .regWrite    (regWrite    ),
        .illegal     (illegal     ),
        .wbValid     (wbValid     ),
        .illegalInstr(illegalInstr),
        .wbAddr      (wbAddr      ),
        .wbData      (wbData      )
    );

endmodule

/* verification/clockGen.sv */
/*
  Clock and reset source for the testbench.
  Clock runs with a 4 ns period, and arstN is held low for the first two cycles.
*/
`timescale 1ns/1ns

module clockGen (
    output logic Clock,
    output logic arstN
);

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge Clock);
        arstN <= 1'b1;
    end

endmodule

/* verification/decodeExecTb.sv */
/*
  Testbench for the decode and execute slice.
  Applies a table of directed words, then an LFSR-driven stream, and
  checks every write-back against a shadow register model.
*/
`timescale 1ns/1ns

module decodeExecTb;
    import mipsPkg::*;

    localparam int randCount  = 200;
    localparam int sweepCount = 31;

    typedef struct packed {
        logic    valid;
        logic    illegal;
        regAddrT addr;
        wordT    data;
    } expT;

    logic    Clock, arstN;
    wordT    instruction;
    logic    instrValid;
    logic    flagIllegal;  // Table classification of the issued word
    logic    wbValid, illegalInstr;
    regAddrT wbAddr;
    wordT    wbData;

    wordT        tableWord [$];
    bit          tableIllegal [$];
    int          tableGap [$];
    wordT        shadowRegs [32];
    expT         expQ [$];
    logic [31:0] lfsrState = 32'h6fb2;
    int          errorCount = 0;
    int          checkCount = 0;
    bit          tableReady = 0;

    funcT rFuncs [16] = '{funcAdd, funcAddu, funcSub, funcSubu, funcAnd, funcOr, funcXor,
                          funcNor, funcSlt, funcSltu, funcSll, funcSrl, funcSra, funcSllv,
                          funcSrlv, funcSrav};
    opcodeT iOps [8] = '{opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opSltiu, opLui};

    clockGen clk0 (.Clock(Clock), .arstN(arstN));

    decodeExecTop #(.regCount(32)) UUT (
        .Clock       (Clock       ),
        .arstN       (arstN       ),
        .instruction (instruction ),
        .instrValid  (instrValid  ),
        .wbValid     (wbValid     ),
        .wbAddr      (wbAddr      ),
        .wbData      (wbData      ),
        .illegalInstr(illegalInstr)
    );

    function automatic wordT rTypeWord(opcodeT op, funcT fn, regAddrT rd, regAddrT rs,
                                       regAddrT rt, shamtT sh);
        return {op, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT immWord(opcodeT op, regAddrT rt, regAddrT rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic lfsrNext();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsrNext()};
        return v;
    endfunction

    function automatic wordT pickInstr();
        int      kind;
        regAddrT rs, rt, rd;
        kind = randomBits(5) % 25;
        rs   = regAddrT'(randomBits(3));  // Low registers only, for dependencies
        rt   = regAddrT'(randomBits(3));
        rd   = regAddrT'(randomBits(3));
        if (kind < 16)
            return rTypeWord(opRType, rFuncs[kind], rd, rs, rt, shamtT'(randomBits(5)));
        else if (kind == 16)
            return rTypeWord(opSpecial2, funcMul, rd, rs, rt, 5'd0);
        else
            return immWord(iOps[kind - 17], rt, rs, randomBits(16));
    endfunction

    function automatic wordT readShadow(regAddrT r);
        return (r == 0) ? '0 : shadowRegs[r];
    endfunction

    function automatic expT modelResult(wordT word);
        expT  e;
        wordT a, b, se, ze;
        a  = readShadow(word[25:21]);
        b  = readShadow(word[20:16]);
        se = {{16{word[15]}}, word[15:0]};
        ze = {16'h0000, word[15:0]};
        e  = '0;
        e.valid = 1'b1;
        e.addr  = word[15:11];
        case (word[31:26])
            opRType: begin
                case (word[5:0])
                    funcAdd, funcAddu: e.data = a + b;
                    funcSub, funcSubu: e.data = a - b;
                    funcAnd:  e.data = a & b;
                    funcOr:   e.data = a | b;
                    funcXor:  e.data = a ^ b;
                    funcNor:  e.data = ~(a | b);
                    funcSlt:  e.data = {31'd0, $signed(a) < $signed(b)};
                    funcSltu: e.data = {31'd0, a < b};
                    funcSll:  e.data = b << word[10:6];
                    funcSrl:  e.data = b >> word[10:6];
                    funcSra:  e.data = $signed(b) >>> word[10:6];
                    funcSllv: e.data = b << a[4:0];
                    funcSrlv: e.data = b >> a[4:0];
                    funcSrav: e.data = $signed(b) >>> a[4:0];
                    default:  e.valid = 1'b0;
                endcase
            end
            opSpecial2: begin
                if (word[5:0] == funcMul)
                    e.data = a * b;  // Low half only
                else
                    e.valid = 1'b0;
            end
            default: begin
                e.addr = word[20:16];
                case (word[31:26])
                    opAddi, opAddiu: e.data = a + se;
                    opSlti:  e.data = {31'd0, $signed(a) < $signed(se)};
                    opSltiu: e.data = {31'd0, a < se};
                    opAndi:  e.data = a & ze;
                    opOri:   e.data = a | ze;
                    opXori:  e.data = a ^ ze;
                    opLui:   e.data = {word[15:0], 16'h0000};
                    default: e.valid = 1'b0;
                endcase
            end
        endcase
        e.illegal = !e.valid;
        return e;
    endfunction

    task automatic checkWriteBack(expT e);
        checkCount++;
        if (wbValid !== e.valid) begin
            errorCount++;
            $display("ERROR %0t: wbValid is %b, expected %b", $time, wbValid, e.valid);
        end
        if (illegalInstr !== e.illegal) begin
            errorCount++;
            $display("ERROR %0t: illegalInstr is %b, expected %b", $time, illegalInstr,
                     e.illegal);
        end
        if (e.valid && wbAddr !== e.addr) begin
            errorCount++;
            $display("ERROR %0t: wbAddr is %0d, expected %0d", $time, wbAddr, e.addr);
        end
        if (e.valid && wbData !== e.data) begin
            errorCount++;
            $display("ERROR %0t: wbData is %h, expected %h", $time, wbData, e.data);
        end
    endtask

    task automatic addEntry(wordT word, bit illegal, int gap);
        tableWord.push_back(word);
        tableIllegal.push_back(illegal);
        tableGap.push_back(gap);
    endtask

    task automatic issue(wordT word, bit illegal, int gap);
        @(posedge Clock);
        instruction <= word;
        instrValid  <= 1'b1;
        flagIllegal <= illegal;
        repeat (gap) begin
            @(posedge Clock);
            instrValid <= 1'b0;
        end
    endtask

    // Write-back of the word issued two cycles back lands before the new read
    always @(negedge Clock) begin : modelStep
        expT done;
        expT next;
        if (arstN !== 1'b1) begin
            expQ.delete();
            expQ.push_back('0);
            expQ.push_back('0);
            foreach (shadowRegs[i])
                shadowRegs[i] = '0;
        end else begin
            done = expQ.pop_front();
            checkWriteBack(done);
            if (done.valid && done.addr != 0)
                shadowRegs[done.addr] = done.data;
            next = '0;
            if (instrValid) begin
                next = modelResult(instruction);
                if (next.illegal !== flagIllegal) begin
                    errorCount++;
                    $display("Table word %h is marked wrongly as legal or illegal", instruction);
                end
            end
            expQ.push_back(next);
        end
    end

    initial begin
        instruction = '0;
        instrValid  = 1'b0;
        flagIllegal = 1'b0;
        for (int k = 1; k < 32; k++)
            addEntry(rTypeWord(opRType, funcOr, regAddrT'(k), regAddrT'(k), 0, 0), 0, 0);
        addEntry(immWord(opAddi, 1, 0, 16'hfffb), 0, 1);  // -5
        addEntry(immWord(opAndi, 2, 1, 16'hf0f0), 0, 1);
        addEntry(immWord(opOri, 3, 0, 16'h8001), 0, 1);
        addEntry(immWord(opXori, 4, 1, 16'hffff), 0, 1);
        addEntry(immWord(opSlti, 5, 1, 16'hffff), 0, 1);
        addEntry(immWord(opSltiu, 6, 3, 16'hffff), 0, 1);
        addEntry(immWord(opLui, 7, 0, 16'h8765), 0, 2);
        addEntry(immWord(opOri, 7, 7, 16'h4321), 0, 1);
        addEntry(immWord(opAddiu, 8, 0, 16'h7fff), 0, 2);
        for (int i = 0; i < 10; i++)
            addEntry(rTypeWord(opRType, rFuncs[i], regAddrT'(9 + i), 7, 1, 0), 0, 1);
        addEntry(rTypeWord(opRType, funcSlt, 19, 1, 3, 0), 0, 1);
        addEntry(rTypeWord(opRType, funcSltu, 20, 1, 3, 0), 0, 1);
        addEntry(rTypeWord(opSpecial2, funcMul, 21, 1, 7, 0), 0, 1);
        for (int i = 10; i < 16; i++)
            addEntry(rTypeWord(opRType, rFuncs[i], regAddrT'(12 + i), 4, 7, 5'd7), 0, 1);
        addEntry(rTypeWord(opRType, funcAdd, 0, 7, 8, 0), 0, 1);  // $0 stays zero
        addEntry(rTypeWord(opRType, funcOr, 28, 0, 0, 0), 0, 1);
        addEntry(immWord(opAddi, 29, 0, 16'd100), 0, 0);
        addEntry(immWord(opAddi, 30, 29, 16'd1), 0, 0);  // Old value of $29
        addEntry(immWord(opAddi, 31, 29, 16'd2), 0, 2);  // New value of $29
        addEntry(immWord(6'h3f, 7, 1, 16'h1234), 1, 1);
        addEntry(immWord(6'h23, 9, 0, 16'h0000), 1, 1);  // lw is not supported
        addEntry(rTypeWord(opRType, 6'h08, 10, 7, 1, 0), 1, 1);
        addEntry(rTypeWord(opRType, 6'h3f, 11, 7, 1, 0), 1, 1);
        addEntry(rTypeWord(opSpecial2, 6'h00, 12, 7, 1, 0), 1, 2);
        tableReady = 1'b1;
        wait (arstN === 1'b1);
        for (int i = 0; i < tableWord.size(); i++)
            issue(tableWord[i], tableIllegal[i], tableGap[i]);
        for (int n = 0; n < randCount; n++)
            issue(pickInstr(), 0, 0);
        for (int k = 1; k < 32; k++)
            issue(rTypeWord(opRType, funcOr, regAddrT'(k), regAddrT'(k), 0, 0), 0, 0);
        @(posedge Clock);
        instrValid <= 1'b0;
        repeat (4) @(posedge Clock);  // Drain both pipeline stages
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        wait (tableReady);
        #((tableWord.size() + randCount + sweepCount) * 4 * 4 + 200);
        $display("Timeout: the tests did not reach their end in time");
        $display("Errors found");
        $finish;
    end

endmodule

/* verilog.f */
design/mipsPkg.sv
design/controlDecoder.sv
design/registerFile.sv
design/immediateGen.sv
design/decodeStage.sv
design/aluUnit.sv
design/executeStage.sv
design/decodeExecTop.sv
verification/clockGen.sv
verification/decodeExecTb.sv
